// File: hdl/resize_pkg.sv
// ==================================================
// Image sizes, widths and types of the resize engine
// Units refer to these by scoped name
// ==================================================
package resize_pkg;

    // ==================================================
    // Image and memory sizes
    // ==================================================
    localparam int SRC_WIDTH       = 160;
    localparam int SRC_HEIGHT      = 120;
    localparam int MAX_WIDTH       = 320;   // Frame RAM limit
    localparam int MAX_HEIGHT      = 240;
    localparam int ROM_LATENCY     = 3;     // Stable address to valid pixel
    localparam int MAX_SCALE_SHIFT = 3;     // Scale 8

    // Derived widths
    localparam int PIXEL_W    = 8;
    localparam int COORD_W    = $clog2((SRC_WIDTH << MAX_SCALE_SHIFT) + 1);
    localparam int ROM_ADDR_W = $clog2(SRC_WIDTH * SRC_HEIGHT);
    localparam int RAM_ADDR_W = $clog2(MAX_WIDTH * MAX_HEIGHT);
    localparam int SHIFT_W    = 2;
    localparam int ACCUM_W    = PIXEL_W + 2 * MAX_SCALE_SHIFT;  // 64 pixels of 255
    localparam int LAT_CNT_W  = $clog2(ROM_LATENCY + 1);

    // ==================================================
    // Types
    // ==================================================
    typedef logic [PIXEL_W-1:0]    pixel_t;
    typedef logic [COORD_W-1:0]    coord_t;
    typedef logic [ROM_ADDR_W-1:0] rom_addr_t;
    typedef logic [RAM_ADDR_W-1:0] ram_addr_t;
    typedef logic [SHIFT_W-1:0]    scale_shift_t;   // log2 of the scale
    typedef logic [ACCUM_W-1:0]    accum_t;

    typedef enum logic [0:0] {
        MODE_NEAREST,     // Zoom in with centered crop
        MODE_BLOCK_AVG    // Zoom out by block mean
    } resize_mode_e;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_SETUP,
        ST_FETCH,
        ST_WAIT,
        ST_ACCUM,
        ST_WRITE,
        ST_FINISH
    } seq_state_e;

endpackage

// File: hdl/frame_geom_if.sv
// ==================================================
// Geometry of one resize run, held from setup
// until the next start
// ==================================================
`timescale 1ns/10ps

interface frame_geom_if;

    resize_pkg::resize_mode_e mode;
    resize_pkg::scale_shift_t scale_shift;
    resize_pkg::coord_t       dest_width;    // Output frame size
    resize_pkg::coord_t       dest_height;
    resize_pkg::coord_t       crop_x;        // Window offset in the enlarged image
    resize_pkg::coord_t       crop_y;

    // Geometry unit side
    modport producer (output mode, scale_shift, dest_width, dest_height, crop_x, crop_y);

    // Sequencer, address generator and averager
    modport consumer (input mode, scale_shift, dest_width, dest_height, crop_x, crop_y);

endinterface

// File: hdl/scan_if.sv
// ==================================================
// Current scan position, output pixel and offset
// inside its source block
// ==================================================
`timescale 1ns/10ps

interface scan_if;

    resize_pkg::coord_t dest_x;    // Output pixel
    resize_pkg::coord_t dest_y;
    resize_pkg::coord_t local_x;   // Position inside the block
    resize_pkg::coord_t local_y;

    modport source (output dest_x, dest_y, local_x, local_y);
    modport sink   (input  dest_x, dest_y, local_x, local_y);

endinterface

// File: hdl/resize_geometry.sv
// ==================================================
// Latches mode and zoom on an accepted start and
// registers output size and centered crop offsets
// ==================================================
`timescale 1ns/10ps

module resize_geometry (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     start,
    input  resize_pkg::resize_mode_e mode_in,
    input  resize_pkg::scale_shift_t zoom_select,
    input  logic                     busy,
    frame_geom_if.producer           geom
);

    resize_pkg::coord_t big_w;     // Enlarged size before crop
    resize_pkg::coord_t big_h;
    resize_pkg::coord_t fit_w;     // Enlarged size clipped to the RAM
    resize_pkg::coord_t fit_h;
    resize_pkg::coord_t next_w;
    resize_pkg::coord_t next_h;
    resize_pkg::coord_t next_cx;
    resize_pkg::coord_t next_cy;
    logic               capture;

    assign capture = start && !busy;   // Start during a run is ignored

    assign big_w = resize_pkg::coord_t'(resize_pkg::SRC_WIDTH) << zoom_select;
    assign big_h = resize_pkg::coord_t'(resize_pkg::SRC_HEIGHT) << zoom_select;

    assign fit_w = (big_w > resize_pkg::MAX_WIDTH) ?
                   resize_pkg::coord_t'(resize_pkg::MAX_WIDTH) : big_w;
    assign fit_h = (big_h > resize_pkg::MAX_HEIGHT) ?
                   resize_pkg::coord_t'(resize_pkg::MAX_HEIGHT) : big_h;

    always_comb begin
        if (mode_in == resize_pkg::MODE_NEAREST) begin
            next_w  = fit_w;
            next_h  = fit_h;
            next_cx = (big_w - fit_w) >> 1;    // Half of the cut-off part
            next_cy = (big_h - fit_h) >> 1;
        end else begin
            next_w  = resize_pkg::coord_t'(resize_pkg::SRC_WIDTH) >> zoom_select;
            next_h  = resize_pkg::coord_t'(resize_pkg::SRC_HEIGHT) >> zoom_select;
            next_cx = '0;
            next_cy = '0;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            geom.mode        <= resize_pkg::MODE_NEAREST;
            geom.scale_shift <= '0;
            geom.dest_width  <= '0;
            geom.dest_height <= '0;
            geom.crop_x      <= '0;
            geom.crop_y      <= '0;
        end else if (capture) begin
            geom.mode        <= mode_in;
            geom.scale_shift <= zoom_select;
            geom.dest_width  <= next_w;
            geom.dest_height <= next_h;
            geom.crop_x      <= next_cx;
            geom.crop_y      <= next_cy;
        end
    end

    // Frame must fit the RAM for any mode and zoom
    dims_fit_ram: assert property (@(posedge clk) disable iff (rst)
        (geom.dest_width <= resize_pkg::MAX_WIDTH) &&
        (geom.dest_height <= resize_pkg::MAX_HEIGHT))
        else $error("Output frame larger than the RAM");

endmodule

// File: hdl/resize_sequencer.sv
// ==================================================
// Main FSM, walks output pixels and block positions,
// paces ROM reads and writes each mean to the RAM
// ==================================================
`timescale 1ns/10ps

module resize_sequencer (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  start,
    frame_geom_if.consumer        geom,
    scan_if.source                scan,
    input  resize_pkg::rom_addr_t src_addr,
    output resize_pkg::rom_addr_t rom_addr,
    output logic                  accum_en,
    output logic                  block_first,
    input  resize_pkg::pixel_t    avg_pixel,
    output logic                  busy,
    output resize_pkg::ram_addr_t ram_addr,
    output resize_pkg::pixel_t    pixel_out,
    output logic                  wren,
    output logic                  done
);

    resize_pkg::seq_state_e state;
    resize_pkg::coord_t     dest_x;
    resize_pkg::coord_t     dest_y;
    resize_pkg::coord_t     local_x;
    resize_pkg::coord_t     local_y;
    resize_pkg::coord_t     block_max;          // Last local index in a block
    logic [resize_pkg::LAT_CNT_W-1:0]   lat_cnt;
    logic [2*resize_pkg::COORD_W-1:0]   dest_index;
    logic [2*resize_pkg::COORD_W-1:0]   frame_size;
    logic                   last_local;
    logic                   last_col;
    logic                   last_row;

    // ==================================================
    // Scan decode
    // ==================================================
    // Nearest mode reads a block of one pixel
    assign block_max = (geom.mode == resize_pkg::MODE_NEAREST) ? '0 :
                       (resize_pkg::coord_t'(1) << geom.scale_shift) - resize_pkg::coord_t'(1);

    assign last_local = (local_x == block_max) && (local_y == block_max);
    assign last_col   = dest_x == geom.dest_width - resize_pkg::coord_t'(1);
    assign last_row   = dest_y == geom.dest_height - resize_pkg::coord_t'(1);

    assign dest_index = dest_y * geom.dest_width + dest_x;   // Row-major RAM index
    assign frame_size = geom.dest_width * geom.dest_height;

    assign scan.dest_x  = dest_x;
    assign scan.dest_y  = dest_y;
    assign scan.local_x = local_x;
    assign scan.local_y = local_y;

    assign busy        = state != resize_pkg::ST_IDLE;
    assign accum_en    = state == resize_pkg::ST_ACCUM;
    assign block_first = accum_en && (local_x == '0) && (local_y == '0);

    // ==================================================
    // FSM
    // ==================================================
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= resize_pkg::ST_IDLE;
            dest_x   <= '0;
            dest_y   <= '0;
            local_x  <= '0;
            local_y  <= '0;
            lat_cnt  <= '0;
            rom_addr <= '0;
            ram_addr <= '0;
            wren     <= 1'b0;
            done     <= 1'b0;
        end else begin
            wren <= 1'b0;   // Strobes last one cycle
            done <= 1'b0;
            case (state)
                resize_pkg::ST_IDLE: begin
                    if (start)
                        state <= resize_pkg::ST_SETUP;
                end
                resize_pkg::ST_SETUP: begin
                    state <= resize_pkg::ST_FETCH;   // Geometry now valid
                end
                resize_pkg::ST_FETCH: begin
                    rom_addr <= src_addr;
                    lat_cnt  <= '0;
                    state    <= resize_pkg::ST_WAIT;
                end
                resize_pkg::ST_WAIT: begin
                    if (lat_cnt == resize_pkg::LAT_CNT_W'(resize_pkg::ROM_LATENCY - 1))
                        state <= resize_pkg::ST_ACCUM;
                    else
                        lat_cnt <= lat_cnt + 1'b1;
                end
                resize_pkg::ST_ACCUM: begin
                    if (last_local) begin
                        local_x <= '0;
                        local_y <= '0;
                        state   <= resize_pkg::ST_WRITE;
                    end else begin
                        if (local_x == block_max) begin
                            local_x <= '0;
                            local_y <= local_y + 1'b1;
                        end else begin
                            local_x <= local_x + 1'b1;
                        end
                        state <= resize_pkg::ST_FETCH;
                    end
                end
                resize_pkg::ST_WRITE: begin
                    ram_addr <= dest_index[resize_pkg::RAM_ADDR_W-1:0];
                    wren     <= 1'b1;
                    if (last_col) begin
                        dest_x <= '0;
                        if (last_row) begin
                            dest_y <= '0;   // Leaves the scan at the origin
                            state  <= resize_pkg::ST_FINISH;
                        end else begin
                            dest_y <= dest_y + 1'b1;
                            state  <= resize_pkg::ST_FETCH;
                        end
                    end else begin
                        dest_x <= dest_x + 1'b1;
                        state  <= resize_pkg::ST_FETCH;
                    end
                end
                resize_pkg::ST_FINISH: begin
                    done  <= 1'b1;   // One cycle after the last write
                    state <= resize_pkg::ST_IDLE;
                end
                default: state <= resize_pkg::ST_IDLE;
            endcase
        end
    end

    // Write data, taken while the mean is valid
    always_ff @(posedge clk) begin
        if (state == resize_pkg::ST_WRITE)
            pixel_out <= avg_pixel;
    end

    // ==================================================
    // Checks
    // ==================================================
    wren_done_apart: assert property (@(posedge clk) disable iff (rst)
        !(wren && done))
        else $error("wren and done high together");

    write_in_frame: assert property (@(posedge clk) disable iff (rst)
        wren |-> (ram_addr < frame_size))
        else $error("RAM write outside the output frame");

endmodule

// File: hdl/src_address_gen.sv
// ==================================================
// Maps the scan position to a row-major source
// ROM address, nearest or block mode
// ==================================================
`timescale 1ns/10ps

module src_address_gen (
    frame_geom_if.consumer        geom,
    scan_if.sink                  scan,
    output resize_pkg::rom_addr_t src_addr
);

    resize_pkg::coord_t src_x;
    resize_pkg::coord_t src_y;

    always_comb begin
        if (geom.mode == resize_pkg::MODE_NEAREST) begin
            // Window position plus crop, back to source scale
            src_x = (scan.dest_x + geom.crop_x) >> geom.scale_shift;
            src_y = (scan.dest_y + geom.crop_y) >> geom.scale_shift;
        end else begin
            src_x = (scan.dest_x << geom.scale_shift) + scan.local_x;  // Block corner plus offset
            src_y = (scan.dest_y << geom.scale_shift) + scan.local_y;
        end
    end

    assign src_addr = resize_pkg::rom_addr_t'(src_y * resize_pkg::SRC_WIDTH + src_x);

    // Any reachable scan position lands inside the source image
    always_comb begin
        src_in_image: assert #0 ((src_x < resize_pkg::SRC_WIDTH) &&
                                 (src_y < resize_pkg::SRC_HEIGHT))
            else $error("Source coordinate outside the image");
    end

endmodule

// File: hdl/block_averager.sv
// ==================================================
// Sums the pixels of one block and gives their mean,
// a single pixel passes through in nearest mode
// ==================================================
`timescale 1ns/10ps

module block_averager (
    input  logic               clk,
    input  logic               rst,
    frame_geom_if.consumer     geom,
    input  logic               accum_en,
    input  logic               block_first,
    input  resize_pkg::pixel_t pixel_in,
    output resize_pkg::pixel_t avg_pixel
);

    resize_pkg::accum_t accum;
    logic [resize_pkg::SHIFT_W:0] div_shift;   // log2 of the pixels per block

    // Block of scale x scale pixels, one pixel when zooming in
    assign div_shift = (geom.mode == resize_pkg::MODE_NEAREST) ? '0 :
                       {geom.scale_shift, 1'b0};

    assign avg_pixel = resize_pkg::pixel_t'(accum >> div_shift);   // Rounds down

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            accum <= '0;
        end else if (accum_en) begin
            if (block_first)
                accum <= resize_pkg::accum_t'(pixel_in);   // Restart on a new block
            else
                accum <= accum + resize_pkg::accum_t'(pixel_in);
        end
    end

endmodule

// File: hdl/resize_top.sv
// ==================================================
// Resize engine top, source ROM in and frame RAM
// write strobes out on plain ports
// ==================================================
`timescale 1ns/10ps

module resize_top (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              start,
    input  logic                              mode,          // 0 nearest, 1 block average
    input  logic [resize_pkg::SHIFT_W-1:0]    zoom_select,   // log2 of the scale
    input  logic [resize_pkg::PIXEL_W-1:0]    pixel_in,
    output logic [resize_pkg::ROM_ADDR_W-1:0] rom_addr,
    output logic [resize_pkg::RAM_ADDR_W-1:0] ram_addr,
    output logic [resize_pkg::PIXEL_W-1:0]    pixel_out,
    output logic                              wren,
    output logic                              done
);

    resize_pkg::rom_addr_t src_addr;
    resize_pkg::pixel_t    avg_pixel;
    logic                  accum_en;
    logic                  block_first;
    logic                  busy;

    frame_geom_if geom_bus ();
    scan_if       scan_bus ();

    resize_geometry u_geometry (
        .clk         (clk),
        .rst         (rst),
        .start       (start),
        .mode_in     (resize_pkg::resize_mode_e'(mode)),
        .zoom_select (zoom_select),
        .busy        (busy),
        .geom        (geom_bus.producer)
    );

    resize_sequencer u_sequencer (
        .clk         (clk),
        .rst         (rst),
        .start       (start),
        .geom        (geom_bus.consumer),
        .scan        (scan_bus.source),
        .src_addr    (src_addr),
        .rom_addr    (rom_addr),
        .accum_en    (accum_en),
        .block_first (block_first),
        .avg_pixel   (avg_pixel),
        .busy        (busy),
        .ram_addr    (ram_addr),
        .pixel_out   (pixel_out),
        .wren        (wren),
        .done        (done)
    );

    src_address_gen u_addr_gen (
        .geom     (geom_bus.consumer),
        .scan     (scan_bus.sink),
        .src_addr (src_addr)
    );

    block_averager u_averager (
        .clk         (clk),
        .rst         (rst),
        .geom        (geom_bus.consumer),
        .accum_en    (accum_en),
        .block_first (block_first),
        .pixel_in    (pixel_in),
        .avg_pixel   (avg_pixel)
    );

endmodule

// File: verification/rom_model.sv
// ==================================================
// Source ROM model with a registered read that is
// ROM_LATENCY stages deep, contents set by the testbench
// ==================================================
`timescale 1ns/10ps

module rom_model (
    input  logic                  clk,
    input  resize_pkg::rom_addr_t addr,
    output resize_pkg::pixel_t    data
);

    // Written directly by the testbench before any run
    resize_pkg::pixel_t mem [resize_pkg::SRC_WIDTH * resize_pkg::SRC_HEIGHT];
    resize_pkg::pixel_t pipe [resize_pkg::ROM_LATENCY];

    always_ff @(posedge clk) begin
        pipe[0] <= mem[addr];
        for (int i = 1; i < resize_pkg::ROM_LATENCY; i++) begin
            pipe[i] <= pipe[i-1];   // Delay line
        end
    end

    assign data = pipe[resize_pkg::ROM_LATENCY-1];

endmodule

// File: verification/tb_resize.sv
// ==================================================
// Directed tests of the resize engine, RAM writes are
// captured and compared with the resize rules
// ==================================================
`timescale 1ns/10ps

module tb_resize;

    localparam int SEED     = 91322;
    localparam int SRC_W    = resize_pkg::SRC_WIDTH;
    localparam int SRC_H    = resize_pkg::SRC_HEIGHT;
    localparam int RAM_SIZE = resize_pkg::MAX_WIDTH * resize_pkg::MAX_HEIGHT;

    logic                  clk = 1'b0;
    logic                  rst;
    logic                  start;
    logic                  mode;
    logic [1:0]            zoom_select;
    resize_pkg::pixel_t    pixel_in;
    resize_pkg::rom_addr_t rom_addr;
    resize_pkg::ram_addr_t ram_addr;
    resize_pkg::pixel_t    pixel_out;
    logic                  wren;
    logic                  done;

    int     src_img [SRC_W * SRC_H];
    int     ram_img [RAM_SIZE];
    int     wr_count [RAM_SIZE];
    int     wren_total;
    int     done_count;
    logic   prev_wren;
    longint cycle_count;
    longint cycle_limit;

    always #10 clk = ~clk;

    resize_top UUT (
        .clk (clk), .rst (rst), .start (start), .mode (mode),
        .zoom_select (zoom_select), .pixel_in (pixel_in), .rom_addr (rom_addr),
        .ram_addr (ram_addr), .pixel_out (pixel_out), .wren (wren), .done (done)
    );

    rom_model u_rom (.clk (clk), .addr (rom_addr), .data (pixel_in));

    // ==================================================
    // Reporting and reference rules
    // ==================================================
    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("Some tests failed");
        $fatal(1, "Simulation stopped on the first failure");
    endtask

    task automatic check_value(input string name, input int actual, input int expected);
        if (actual != expected) begin
            $display("ERR time=%0t %s actual=%0d expected=%0d", $time, name, actual, expected);
            fail_run("Value mismatch");
        end
    endtask

    // Output size along one axis
    function automatic int frame_dim(input int run_mode, input int zs, input int src, input int lim);
        if (run_mode == 1)
            return src >> zs;
        return ((src << zs) < lim) ? (src << zs) : lim;
    endfunction

    function automatic int ref_pixel(input int run_mode, input int zs, input int cx,
                                     input int cy, input int x, input int y);
        int scale;
        int sum;
        scale = 1 << zs;
        sum   = 0;
        if (run_mode == 0)
            return src_img[((y + cy) / scale) * SRC_W + (x + cx) / scale];
        for (int j = 0; j < scale; j++)
            for (int i = 0; i < scale; i++)
                sum += src_img[(y * scale + j) * SRC_W + x * scale + i];
        return sum / (scale * scale);   // Rounds down
    endfunction

    // Reads cost fetch, wait and accumulate, each write one cycle
    function automatic longint run_estimate(input int run_mode, input int zs);
        longint writes;
        longint block;
        writes = frame_dim(run_mode, zs, SRC_W, resize_pkg::MAX_WIDTH) *
                 frame_dim(run_mode, zs, SRC_H, resize_pkg::MAX_HEIGHT);
        block  = (run_mode == 1) ? (1 << (2 * zs)) : 1;
        return writes * block * (resize_pkg::ROM_LATENCY + 2) + writes;
    endfunction

    // ==================================================
    // Monitor and timeout
    // ==================================================
    always @(negedge clk) begin
        if (wren && ram_addr >= RAM_SIZE) begin
            fail_run("RAM write beyond the frame RAM");
        end else if (wren) begin
            ram_img[ram_addr] = int'(pixel_out);
            wr_count[ram_addr]++;
            wren_total++;
        end
        if (done) begin
            done_count++;
            check_value("wren_before_done", int'(prev_wren), 1);
        end
        prev_wren = wren;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > cycle_limit)
            fail_run($sformatf("Run timed out after %0d cycles", cycle_count));
    end

    // ==================================================
    // Run helpers
    // ==================================================
    task automatic clear_capture();
        for (int a = 0; a < RAM_SIZE; a++) begin
            ram_img[a]  = 0;
            wr_count[a] = 0;
        end
        wren_total = 0;
    endtask

    task automatic start_pulse(input int run_mode, input int zs);
        @(posedge clk);
        #2;
        mode        = run_mode[0];
        zoom_select = zs[1:0];
        start       = 1'b1;
        @(posedge clk);
        #2;
        start = 1'b0;
    endtask

    task automatic wait_done(input int done_before);
        while (done_count == done_before)
            @(posedge clk);
        repeat (3) @(posedge clk);   // Catch a stray second done
        check_value("done_pulses", done_count - done_before, 1);
    endtask

    // Every window address once with the reference value, nothing outside
    task automatic verify_frame(input int run_mode, input int zs, input int cx, input int cy);
        int w;
        int h;
        w = frame_dim(run_mode, zs, SRC_W, resize_pkg::MAX_WIDTH);
        h = frame_dim(run_mode, zs, SRC_H, resize_pkg::MAX_HEIGHT);
        check_value("wren_pulses", wren_total, w * h);
        for (int a = 0; a < RAM_SIZE; a++) begin
            if (a < w * h) begin
                check_value($sformatf("write_count[%0d]", a), wr_count[a], 1);
                check_value($sformatf("pixel_out[%0d]", a), ram_img[a],
                            ref_pixel(run_mode, zs, cx, cy, a % w, a / w));
            end else begin
                check_value($sformatf("write_count[%0d]", a), wr_count[a], 0);
            end
        end
    endtask

    task automatic run_and_verify(input int run_mode, input int zs, input int cx, input int cy);
        int done_before;
        done_before = done_count;
        clear_capture();
        start_pulse(run_mode, zs);
        wait_done(done_before);
        verify_frame(run_mode, zs, cx, cy);
    endtask

    // ==================================================
    // Directed tests
    // ==================================================
    task automatic test_reset_quiet();
        repeat (2) begin
            @(posedge clk);
            #2;
            check_value("wren", int'(wren), 0);
            check_value("done", int'(done), 0);
            check_value("rom_addr", int'(rom_addr), 0);
            check_value("ram_addr", int'(ram_addr), 0);
        end
        rst = 1'b0;
        repeat (10) @(posedge clk);
        check_value("wren_pulses", wren_total, 0);   // Idle engine stays silent
        check_value("done_pulses", done_count, 0);
    endtask

    task automatic test_copy();
        run_and_verify(0, 0, 0, 0);
        run_and_verify(1, 0, 0, 0);
    endtask

    task automatic test_zoom_in(input int zs, input int cx, input int cy);
        run_and_verify(0, zs, cx, cy);
    endtask

    task automatic test_zoom_out(input int zs);
        run_and_verify(1, zs, 0, 0);
    endtask

    task automatic test_restart_ignored();
        int done_before;
        done_before = done_count;
        clear_capture();
        start_pulse(1, 1);
        while (wren_total < 100)
            @(posedge clk);
        start_pulse(0, 3);   // Must not disturb the running block average
        wait_done(done_before);
        verify_frame(1, 1, 0, 0);
    endtask

    initial begin
        rst         = 1'b1;
        start       = 1'b0;
        mode        = 1'b0;
        zoom_select = 2'd0;
        wren_total  = 0;
        done_count  = 0;
        prev_wren   = 1'b0;
        cycle_count = 0;
        cycle_limit = 2 * (run_estimate(0, 0) + run_estimate(1, 0) + run_estimate(0, 1) +
                           run_estimate(0, 2) + run_estimate(0, 3) + run_estimate(1, 1) +
                           run_estimate(1, 2) + run_estimate(1, 3) + run_estimate(1, 1));
        void'($urandom(SEED));
        for (int i = 0; i < SRC_W * SRC_H; i++) begin
            src_img[i]   = int'($urandom % 256);
            u_rom.mem[i] = resize_pkg::pixel_t'(src_img[i]);
        end

        test_reset_quiet();
        test_copy();
        test_zoom_in(1, 0, 0);
        test_zoom_in(2, 160, 120);
        test_zoom_in(3, 480, 360);
        test_zoom_out(1);
        test_zoom_out(2);
        test_zoom_out(3);
        test_restart_ignored();

        $display("All tests passed");
        $finish;
    end

endmodule

// File: sim.f
hdl/resize_pkg.sv
hdl/frame_geom_if.sv
hdl/scan_if.sv
hdl/resize_geometry.sv
hdl/resize_sequencer.sv
hdl/src_address_gen.sv
hdl/block_averager.sv
hdl/resize_top.sv
verification/rom_model.sv
verification/tb_resize.sv

// File: run_sim.sh
#!/bin/sh
# Build the resize engine testbench with Verilator, run it and check the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f sim.f \
    --top-module tb_resize --Mdir obj_dir -o tb_resize_sim

./obj_dir/tb_resize_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "All tests passed" sim.log; then
    exit 0
fi
exit 1
